/* fetch_frontend.f */
+incdir+include
hw/pipeline_types.sv
hw/predict_types.sv
hw/timer_irq.sv
hw/frontend_ctrl.sv
hw/btb.sv
hw/pc_reg.sv
hw/fetch_top.sv
tb/fetch_tb.sv

/* hw/btb.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module btb (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ADDR_W-1:0]         fetch_pc,
    input  predict_types::btb_update_t update,
    output predict_types::predict_t    pred
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = `ADDR_W - IDX_W - 2;

    // entry storage, valid is the only reset state
    logic [`BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q    [`BTB_ENTRIES];
    logic [`ADDR_W-1:0]      target_q [`BTB_ENTRIES];
    logic [1:0]              cnt_q    [`BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             rd_hit;
    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;
    logic             upd_hit;
    logic [1:0]       cnt_next;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    // index skips the byte offset bits
    assign rd_idx = fetch_pc[IDX_W+1:2];
    assign rd_tag = fetch_pc[`ADDR_W-1:IDX_W+2];
    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // taken when counter is 2 or 3
    assign pred = '{hit: rd_hit, taken: rd_hit && cnt_q[rd_idx][1],
                    target: target_q[rd_idx]};

    //////////////////////////////////////////////////
    // training
    //////////////////////////////////////////////////

    assign upd_idx = update.pc[IDX_W+1:2];
    assign upd_tag = update.pc[`ADDR_W-1:IDX_W+2];
    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    always_comb begin
        if (!upd_hit) begin
            // fresh entry starts weak, in the resolved direction
            cnt_next = update.taken ? 2'd2 : 2'd1;
        end else if (update.taken) begin
            cnt_next = (cnt_q[upd_idx] == 2'd3) ? 2'd3 : cnt_q[upd_idx] + 2'd1;
        end else begin
            cnt_next = (cnt_q[upd_idx] == 2'd0) ? 2'd0 : cnt_q[upd_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update.valid) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update.target;
            cnt_q[upd_idx]    <= cnt_next;
        end
    end

    // back end only trains on word aligned branches
    a_update_aligned: assert property (@(posedge clk) disable iff (rst)
        update.valid |-> update.pc[1:0] == 2'b00);

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       branch_flush,
    input  logic [`ADDR_W-1:0]         branch_actual_addr,
    input  predict_types::btb_update_t btb_update,
    input  logic [`PAUSE_W-1:0]        pause_req,
    input  logic                       exc_req,
    input  logic [`ADDR_W-1:0]         eentry,
    input  logic                       ertn_req,
    input  logic [`ADDR_W-1:0]         era,
    input  logic                       int_enable,
    input  pipeline_types::timer_cfg_t timer_cfg,
    input  logic                       ticlr,
    output pipeline_types::pc_out_t    pc,
    output logic                       inst_en,
    output logic                       uncache_en,
    output pipeline_types::ctrl_t      ctrl,
    output logic                       irq_pending
);

    import pipeline_types::*;
    import predict_types::*;

    // control fsm to pc register
    ctrl_pc_t ctrl_pc;
    // btb lookup back into pc register
    predict_t pred;

    timer_irq timer_i (
        .clk        (clk),
        .rst        (rst),
        .cfg        (timer_cfg),
        .ticlr      (ticlr),
        .irq_pending(irq_pending)
    );

    frontend_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .exc_req    (exc_req),
        .eentry     (eentry),
        .ertn_req   (ertn_req),
        .era        (era),
        .int_enable (int_enable),
        .irq_pending(irq_pending),
        .pause_req  (pause_req),
        .ctrl       (ctrl),
        .ctrl_pc    (ctrl_pc)
    );

    btb btb_i (
        .clk     (clk),
        .rst     (rst),
        .fetch_pc(pc.pc),
        .update  (btb_update),
        .pred    (pred)
    );

    pc_reg pc_reg_i (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .branch_flush      (branch_flush),
        .branch_actual_addr(branch_actual_addr),
        .pred              (pred),
        .ctrl              (ctrl),
        .ctrl_pc           (ctrl_pc),
        .pc                (pc),
        .inst_en           (inst_en),
        .uncache_en        (uncache_en)
    );

endmodule

/* hw/frontend_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module frontend_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     exc_req,
    input  logic [`ADDR_W-1:0]       eentry,
    input  logic                     ertn_req,
    input  logic [`ADDR_W-1:0]       era,
    input  logic                     int_enable,
    input  logic                     irq_pending,
    input  logic [`PAUSE_W-1:0]      pause_req,
    output pipeline_types::ctrl_t    ctrl,
    output pipeline_types::ctrl_pc_t ctrl_pc
);

    import pipeline_types::*;

    ctrl_state_e         state_q;
    ctrl_op_e            op;
    logic                flush_q;
    logic [`PAUSE_W-1:0] pause_q;
    logic                int_q;
    logic [`ADDR_W-1:0]  new_pc_q;

    //////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////

    always_comb begin
        if (flush_q) begin
            // requests in the flush shadow belong to squashed work
            op = OP_NONE;
        end else if (ertn_req) begin
            op = OP_ERTN;
        end else if (exc_req) begin
            op = OP_EXC;
        end else if (state_q == ST_RUN && int_enable && irq_pending) begin
            // no nesting, handler must ertn first
            op = OP_INT;
        end else begin
            op = OP_NONE;
        end
    end

    //////////////////////////////////////////////////
    // state and registered controls
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_RUN;
            flush_q <= 1'b0;
            int_q   <= 1'b0;
            pause_q <= '0;
        end else begin
            case (op)
                OP_EXC, OP_INT: state_q <= ST_HANDLER;
                OP_ERTN:        state_q <= ST_RUN;
                default:        state_q <= state_q;
            endcase
            // single cycle flush pulse per request
            flush_q <= (op != OP_NONE);
            int_q   <= (op == OP_INT);
            pause_q <= pause_req;
        end
    end

    // redirect target, only looked at with the flush
    always_ff @(posedge clk) begin
        if (op == OP_ERTN) begin
            new_pc_q <= era;
        end else begin
            new_pc_q <= eentry;
        end
    end

    assign ctrl    = '{exception_flush: flush_q, pause: pause_q};
    assign ctrl_pc = '{exception_new_pc: new_pc_q, is_interrupt: int_q};

    // back to back flushes would drop the second target
    a_flush_single: assert property (@(posedge clk) disable iff (rst)
        ctrl.exception_flush |=> !ctrl.exception_flush);

endmodule

/* hw/pc_reg.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pc_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    branch_flush,
    input  logic [`ADDR_W-1:0]      branch_actual_addr,
    input  predict_types::predict_t pred,
    input  pipeline_types::ctrl_t   ctrl,
    input  pipeline_types::ctrl_pc_t ctrl_pc,
    output pipeline_types::pc_out_t pc,
    output logic                    inst_en,
    output logic                    uncache_en
);

    logic [`ADDR_W-1:0] pc_q;
    logic               int_tag_q;
    logic               adef_q;
    logic [6:0]         cause_q;
    logic               misaligned;

    // fetch turns on one cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_en <= 1'b0;
        end else begin
            inst_en <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // next fetch address
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `RESET_PC;
        end else if (!inst_en) begin
            // first cycle out of reset, keep reset address
            pc_q <= pc_q;
        end else if (ctrl.exception_flush) begin
            pc_q <= ctrl_pc.exception_new_pc;
        end else if (ctrl.pause[0]) begin
            // pause blocks branch correction too
            pc_q <= pc_q;
        end else if (branch_flush) begin
            pc_q <= branch_actual_addr;
        end else if (stall) begin
            pc_q <= pc_q;
        end else if (pred.hit && pred.taken) begin
            pc_q <= pred.target;
        end else begin
            pc_q <= pc_q + `ADDR_W'd4;
        end
    end

    assign misaligned = |pc_q[1:0];

    // tags describe the previous cycle's pc
    always_ff @(posedge clk) begin
        int_tag_q <= ctrl_pc.is_interrupt;
        adef_q    <= misaligned;
        // interrupt wins over adef
        if (ctrl_pc.is_interrupt) begin
            cause_q <= `EXC_INT;
        end else if (misaligned) begin
            cause_q <= `EXC_ADEF;
        end else begin
            cause_q <= `EXC_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uncache_en <= 1'b0;
        end else begin
            uncache_en <= (pc_q < `UNCACHE_LIMIT);
        end
    end

    assign pc = '{pc: pc_q, is_interrupt: int_tag_q, is_adef: adef_q,
                  exception_cause: cause_q};

    // fetch pause freezes pc unless a redirect lands
    a_pause_holds: assert property (@(posedge clk) disable iff (rst)
        inst_en && ctrl.pause[0] && !ctrl.exception_flush |=> $stable(pc.pc));

    // a redirect always lands, whatever the pause state
    a_flush_lands: assert property (@(posedge clk) disable iff (rst)
        inst_en && ctrl.exception_flush |=> pc.pc == $past(ctrl_pc.exception_new_pc));

endmodule

/* hw/pipeline_types.sv */
`include "fetch_defines.svh"

package pipeline_types;

    //////////////////////////////////////////////////
    // pipeline control
    //////////////////////////////////////////////////

    // flush and per-stage pause, from the control FSM
    typedef struct packed {
        logic                exception_flush;
        logic [`PAUSE_W-1:0] pause;
    } ctrl_t;

    // redirect target, valid while exception_flush is high
    typedef struct packed {
        logic [`ADDR_W-1:0] exception_new_pc;
        logic               is_interrupt;
    } ctrl_pc_t;

    // fetch output, tags trail pc by a cycle
    typedef struct packed {
        logic [`ADDR_W-1:0] pc;
        logic               is_interrupt;
        logic               is_adef;
        logic [6:0]         exception_cause;
    } pc_out_t;

    // decoded control request, one per cycle
    typedef enum logic [1:0] {
        OP_NONE,
        OP_EXC,
        OP_ERTN,
        OP_INT
    } ctrl_op_e;

    // running normally or inside a handler
    typedef enum logic {
        ST_RUN,
        ST_HANDLER
    } ctrl_state_e;

    // timer programming word
    typedef struct packed {
        logic        wr;
        logic        enable;
        logic        periodic;
        logic [31:0] init;
    } timer_cfg_t;

endpackage

/* hw/predict_types.sv */
`include "fetch_defines.svh"

package predict_types;

    //////////////////////////////////////////////////
    // branch prediction
    //////////////////////////////////////////////////

    // combinational btb lookup result
    typedef struct packed {
        logic               hit;
        logic               taken;
        logic [`ADDR_W-1:0] target;
    } predict_t;

    // resolved branch from the back end
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] pc;
        logic               taken;
        logic [`ADDR_W-1:0] target;
    } btb_update_t;

endpackage

/* hw/timer_irq.sv */
`timescale 1ns/1ps

module timer_irq (
    input  logic                       clk,
    input  logic                       rst,
    input  pipeline_types::timer_cfg_t cfg,
    input  logic                       ticlr,
    output logic                       irq_pending
);

    logic [31:0] count_q;
    logic [31:0] reload_q;
    logic        en_q;
    logic        periodic_q;
    logic        expire;

    // last count step, a zero load expires at once
    assign expire = en_q && !cfg.wr && (count_q <= 32'd1);

    //////////////////////////////////////////////////
    // countdown
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q    <= '0;
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
        end else if (cfg.wr) begin
            count_q    <= cfg.init;
            en_q       <= cfg.enable;
            periodic_q <= cfg.periodic;
        end else if (expire) begin
            // periodic reloads, one-shot stops
            count_q <= periodic_q ? reload_q : 32'd0;
            en_q    <= periodic_q;
        end else if (en_q) begin
            count_q <= count_q - 32'd1;
        end
    end

    // reload value kept for periodic mode
    always_ff @(posedge clk) begin
        if (cfg.wr) begin
            reload_q <= cfg.init;
        end
    end

    // sticky pending, expiry wins over a same-cycle clear
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= 1'b0;
        end else if (expire) begin
            irq_pending <= 1'b1;
        end else if (ticlr) begin
            irq_pending <= 1'b0;
        end
    end

endmodule

/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

//////////////////////////////////////////////////
// fetch address space
//////////////////////////////////////////////////

// fetch address width
`define ADDR_W 32

// first address fetched once reset is released
`define RESET_PC 32'h0000_00fc

// everything below this boundary bypasses the icache
`define UNCACHE_LIMIT 32'h0000_0200

//////////////////////////////////////////////////
// exception cause codes
//////////////////////////////////////////////////

// no exception, idle code
`define EXC_NOP 7'h7f
// interrupt
`define EXC_INT 7'h00
// fetch address error, misaligned pc
`define EXC_ADEF 7'h08

//////////////////////////////////////////////////
// prediction and pipeline sizing
//////////////////////////////////////////////////

// btb entry count, must be a power of two
`define BTB_ENTRIES 16

// one pause bit per stage, bit 0 is fetch
`define PAUSE_W 4

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator and runs it
# exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module fetch_tb -f fetch_frontend.f -o fetch_sim \
    && ./obj_dir/fetch_sim \
    || { echo "fetch_tb: build or simulation failed"; exit 1; }

/* tb/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb;

    import pipeline_types::*;
    import predict_types::*;

    localparam logic [`ADDR_W-1:0] EENTRY     = 32'h0000_0800;
    localparam logic [`ADDR_W-1:0] ERA        = 32'h0000_0400;
    localparam int                 RST_CYCLES = 4;

    // one cycle of stimulus
    typedef struct packed {
        logic                stall;
        logic                branch_flush;
        logic [`ADDR_W-1:0]  branch_addr;
        btb_update_t         upd;
        logic [`PAUSE_W-1:0] pause_req;
        logic                exc_req;
        logic                ertn_req;
        logic                int_enable;
        timer_cfg_t          timer_cfg;
        logic                ticlr;
    } stim_t;

    // outputs after that row's clock edge
    typedef struct packed {
        logic [`ADDR_W-1:0]  pc;
        logic                is_interrupt;
        logic                is_adef;
        logic [6:0]          cause;
        logic                inst_en;
        logic                uncache_en;
        logic                irq_pending;
        logic                flush;
        logic [`PAUSE_W-1:0] pause;
    } want_t;

    typedef struct packed {
        stim_t stim;
        want_t want;
    } row_t;

    logic                clk;
    logic                rst;
    logic                stall;
    logic                branch_flush;
    logic [`ADDR_W-1:0]  branch_actual_addr;
    btb_update_t         btb_update;
    logic [`PAUSE_W-1:0] pause_req;
    logic                exc_req;
    logic [`ADDR_W-1:0]  eentry;
    logic                ertn_req;
    logic [`ADDR_W-1:0]  era;
    logic                int_enable;
    timer_cfg_t          timer_cfg;
    logic                ticlr;
    pc_out_t             pc;
    logic                inst_en;
    logic                uncache_en;
    ctrl_t               ctrl;
    logic                irq_pending;

    row_t        rows_q[$];
    bit          built;
    logic        int_level;
    logic [31:0] lfsr_q;

    // reference model state
    logic [`ADDR_W-1:0]  m_pc;
    logic                m_inst_en;
    logic                m_uncache;
    logic                m_int_tag;
    logic                m_adef;
    logic [6:0]          m_cause;
    logic                m_flush;
    logic                m_is_int;
    logic                m_in_handler;
    logic [`ADDR_W-1:0]  m_new_pc;
    logic [`PAUSE_W-1:0] m_pause;
    logic [31:0]         m_cnt;
    logic [31:0]         m_reload;
    logic                m_ten;
    logic                m_tper;
    logic                m_pending;
    logic                m_bvalid [`BTB_ENTRIES];
    logic [`ADDR_W-3:0]  m_bword  [`BTB_ENTRIES];
    logic [`ADDR_W-1:0]  m_btgt   [`BTB_ENTRIES];
    int                  m_bctr   [`BTB_ENTRIES];

    fetch_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .branch_flush      (branch_flush),
        .branch_actual_addr(branch_actual_addr),
        .btb_update        (btb_update),
        .pause_req         (pause_req),
        .exc_req           (exc_req),
        .eentry            (eentry),
        .ertn_req          (ertn_req),
        .era               (era),
        .int_enable        (int_enable),
        .timer_cfg         (timer_cfg),
        .ticlr             (ticlr),
        .pc                (pc),
        .inst_en           (inst_en),
        .uncache_en        (uncache_en),
        .ctrl              (ctrl),
        .irq_pending       (irq_pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // galois step with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic stim_t idle_stim();
        stim_t s;
        s            = '0;
        s.int_enable = int_level;
        return s;
    endfunction

    task automatic push(input stim_t s);
        row_t r;
        r.stim = s;
        r.want = '0;
        rows_q.push_back(r);
    endtask

    task automatic push_idle(input int n);
        repeat (n) push(idle_stim());
    endtask

    task automatic apply_stim(input stim_t s);
        stall              = s.stall;
        branch_flush       = s.branch_flush;
        branch_actual_addr = s.branch_addr;
        btb_update         = s.upd;
        pause_req          = s.pause_req;
        exc_req            = s.exc_req;
        ertn_req           = s.ertn_req;
        int_enable         = s.int_enable;
        timer_cfg          = s.timer_cfg;
        ticlr              = s.ticlr;
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        stim_t       s;
        logic [31:0] bits;
        int_level = 1'b0;
        lfsr_q    = 32'hc5cf_a652;
        // straight line fetch from reset address
        push_idle(5);
        // correction beats stall and the walk crosses the uncached boundary
        s = idle_stim();
        s.stall        = 1'b1;
        s.branch_flush = 1'b1;
        s.branch_addr  = 32'h0000_01f8;
        push(s);
        push_idle(4);
        s = idle_stim();
        s.stall = 1'b1;
        push(s);
        push(s);
        // train 0x300 as taken to 0x380
        s = idle_stim();
        s.upd = '{valid: 1'b1, pc: 32'h0000_0300, taken: 1'b1, target: 32'h0000_0380};
        push(s);
        s = idle_stim();
        s.branch_flush = 1'b1;
        s.branch_addr  = 32'h0000_02f8;
        push(s);
        push_idle(5);
        // two not-taken outcomes
        s = idle_stim();
        s.upd = '{valid: 1'b1, pc: 32'h0000_0300, taken: 1'b0, target: 32'h0000_0380};
        push(s);
        push(s);
        s = idle_stim();
        s.branch_flush = 1'b1;
        s.branch_addr  = 32'h0000_02f8;
        push(s);
        push_idle(5);
        // fetch pause blocks a correction but not an exception
        s = idle_stim();
        s.pause_req = 4'b0001;
        push(s);
        s.branch_flush = 1'b1;
        s.branch_addr  = 32'h0000_0600;
        push(s);
        s = idle_stim();
        s.pause_req = 4'b0001;
        s.exc_req   = 1'b1;
        push(s);
        s = idle_stim();
        s.pause_req = 4'b0001;
        push(s);
        s.pause_req = 4'b1010;
        push(s);
        push_idle(3);
        s = idle_stim();
        s.ertn_req = 1'b1;
        push(s);
        push_idle(3);
        // plain exception and return
        s = idle_stim();
        s.exc_req = 1'b1;
        push(s);
        push_idle(3);
        s = idle_stim();
        s.ertn_req = 1'b1;
        push(s);
        push_idle(3);
        // ertn wins when both arrive together
        s.exc_req = 1'b1;
        push(s);
        push_idle(3);
        // return request in the flush shadow is dropped
        s = idle_stim();
        s.exc_req = 1'b1;
        push(s);
        s = idle_stim();
        s.ertn_req = 1'b1;
        push(s);
        push_idle(3);
        push(s);
        push_idle(3);
        // one-shot timer interrupt with no nesting inside the handler
        int_level = 1'b1;
        s = idle_stim();
        s.timer_cfg = '{wr: 1'b1, enable: 1'b1, periodic: 1'b0, init: 32'd5};
        push(s);
        push_idle(12);
        s = idle_stim();
        s.ticlr = 1'b1;
        push(s);
        push_idle(2);
        s = idle_stim();
        s.ertn_req = 1'b1;
        push(s);
        push_idle(4);
        // periodic mode with interrupts masked
        int_level = 1'b0;
        s = idle_stim();
        s.timer_cfg = '{wr: 1'b1, enable: 1'b1, periodic: 1'b1, init: 32'd3};
        push(s);
        push_idle(4);
        s = idle_stim();
        s.ticlr = 1'b1;
        push(s);
        push_idle(4);
        s = idle_stim();
        s.timer_cfg = '{wr: 1'b1, enable: 1'b0, periodic: 1'b0, init: 32'd0};
        push(s);
        s = idle_stim();
        s.ticlr = 1'b1;
        push(s);
        push_idle(2);
        // misaligned correction raises adef
        s = idle_stim();
        s.branch_flush = 1'b1;
        s.branch_addr  = 32'h0000_0702;
        push(s);
        push_idle(3);
        s.branch_addr = 32'h0000_0100;
        push(s);
        push_idle(2);
        // random stalls and corrections
        for (int k = 0; k < 32; k++) begin
            s = idle_stim();
            draw_bits(1, bits);
            s.stall = bits[0];
            draw_bits(2, bits);
            if (bits[1:0] == 2'b00) begin
                draw_bits(10, bits);
                s.branch_flush = 1'b1;
                s.branch_addr  = 32'h0000_1000 + {20'h0, bits[9:0], 2'b00};
            end
            push(s);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    task automatic model_reset();
        m_pc         = `RESET_PC;
        m_inst_en    = 1'b0;
        m_uncache    = 1'b0;
        m_int_tag    = 1'b0;
        m_adef       = 1'b0;
        m_cause      = `EXC_NOP;
        m_flush      = 1'b0;
        m_is_int     = 1'b0;
        m_in_handler = 1'b0;
        m_new_pc     = EENTRY;
        m_pause      = '0;
        m_cnt        = '0;
        m_reload     = '0;
        m_ten        = 1'b0;
        m_tper       = 1'b0;
        m_pending    = 1'b0;
        for (int e = 0; e < `BTB_ENTRIES; e++) begin
            m_bvalid[e] = 1'b0;
            m_bctr[e]   = 0;
        end
    endtask

    task automatic model_step(input stim_t s);
        ctrl_op_e           op;
        int                 idx;
        int                 uidx;
        logic               pred_taken;
        logic               expire;
        logic [`ADDR_W-1:0] nxt_pc;
        // btb sees the pc before this edge
        idx        = int'((m_pc >> 2) % `BTB_ENTRIES);
        pred_taken = m_bvalid[idx] && (m_bword[idx] == m_pc[`ADDR_W-1:2]) && (m_bctr[idx] >= 2);
        // ertn over exc over interrupt and nothing while a flush is out
        if (m_flush) begin
            op = OP_NONE;
        end else if (s.ertn_req) begin
            op = OP_ERTN;
        end else if (s.exc_req) begin
            op = OP_EXC;
        end else if (!m_in_handler && s.int_enable && m_pending) begin
            op = OP_INT;
        end else begin
            op = OP_NONE;
        end
        // next fetch address by priority
        if (!m_inst_en || (!m_flush && m_pause[0])) begin
            nxt_pc = m_pc;
        end else if (m_flush) begin
            nxt_pc = m_new_pc;
        end else if (s.branch_flush) begin
            nxt_pc = s.branch_addr;
        end else if (s.stall) begin
            nxt_pc = m_pc;
        end else if (pred_taken) begin
            nxt_pc = m_btgt[idx];
        end else begin
            nxt_pc = m_pc + 32'd4;
        end
        // tags trail the address by a cycle
        m_int_tag = m_is_int;
        m_adef    = (m_pc[1:0] != 2'b00);
        m_cause   = m_is_int ? `EXC_INT : (m_adef ? `EXC_ADEF : `EXC_NOP);
        m_uncache = (m_pc < `UNCACHE_LIMIT);
        m_inst_en = 1'b1;
        m_pc      = nxt_pc;
        // control outputs
        if (op == OP_EXC || op == OP_INT) begin
            m_in_handler = 1'b1;
        end else if (op == OP_ERTN) begin
            m_in_handler = 1'b0;
        end
        m_flush  = (op != OP_NONE);
        m_is_int = (op == OP_INT);
        m_new_pc = (op == OP_ERTN) ? ERA : EENTRY;
        m_pause  = s.pause_req;
        // timer pending rises on the step from 1 to 0
        expire = m_ten && !s.timer_cfg.wr && (m_cnt == 32'd1 || m_cnt == 32'd0);
        if (s.timer_cfg.wr) begin
            m_cnt    = s.timer_cfg.init;
            m_reload = s.timer_cfg.init;
            m_ten    = s.timer_cfg.enable;
            m_tper   = s.timer_cfg.periodic;
        end else if (expire) begin
            m_cnt = m_tper ? m_reload : 32'd0;
            m_ten = m_tper;
        end else if (m_ten) begin
            m_cnt = m_cnt - 32'd1;
        end
        if (expire) begin
            m_pending = 1'b1;
        end else if (s.ticlr) begin
            m_pending = 1'b0;
        end
        // btb training
        if (s.upd.valid) begin
            uidx = int'((s.upd.pc >> 2) % `BTB_ENTRIES);
            if (m_bvalid[uidx] && m_bword[uidx] == s.upd.pc[`ADDR_W-1:2]) begin
                if (s.upd.taken && m_bctr[uidx] < 3) begin
                    m_bctr[uidx] = m_bctr[uidx] + 1;
                end else if (!s.upd.taken && m_bctr[uidx] > 0) begin
                    m_bctr[uidx] = m_bctr[uidx] - 1;
                end
            end else begin
                m_bctr[uidx] = s.upd.taken ? 2 : 1;
            end
            m_bvalid[uidx] = 1'b1;
            m_bword[uidx]  = s.upd.pc[`ADDR_W-1:2];
            m_btgt[uidx]   = s.upd.target;
        end
    endtask

    task automatic fill_expected();
        row_t r;
        model_reset();
        for (int i = 0; i < rows_q.size(); i++) begin
            r = rows_q[i];
            model_step(r.stim);
            r.want = '{pc: m_pc, is_interrupt: m_int_tag, is_adef: m_adef, cause: m_cause,
                       inst_en: m_inst_en, uncache_en: m_uncache, irq_pending: m_pending,
                       flush: m_flush, pause: m_pause};
            rows_q[i] = r;
        end
    endtask

    task automatic compare_row(input int i, input want_t w);
        check_value($sformatf("row %0d pc", i), pc.pc, w.pc);
        check_value($sformatf("row %0d is_interrupt", i), 32'(pc.is_interrupt),
                    32'(w.is_interrupt));
        check_value($sformatf("row %0d is_adef", i), 32'(pc.is_adef), 32'(w.is_adef));
        check_value($sformatf("row %0d cause", i), 32'(pc.exception_cause), 32'(w.cause));
        check_value($sformatf("row %0d inst_en", i), 32'(inst_en), 32'(w.inst_en));
        check_value($sformatf("row %0d uncache_en", i), 32'(uncache_en), 32'(w.uncache_en));
        check_value($sformatf("row %0d irq_pending", i), 32'(irq_pending), 32'(w.irq_pending));
        check_value($sformatf("row %0d flush", i), 32'(ctrl.exception_flush), 32'(w.flush));
        check_value($sformatf("row %0d pause", i), 32'(ctrl.pause), 32'(w.pause));
    endtask

    //////////////////////////////////////////////////
    // run and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst       = 1'b1;
        eentry    = EENTRY;
        era       = ERA;
        int_level = 1'b0;
        apply_stim(idle_stim());
        build_table();
        fill_expected();
        built = 1'b1;
        // outputs stay quiet under reset
        repeat (RST_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_value("reset inst_en", 32'(inst_en), 32'd0);
            check_value("reset uncache_en", 32'(uncache_en), 32'd0);
            check_value("reset flush", 32'(ctrl.exception_flush), 32'd0);
            check_value("reset pause", 32'(ctrl.pause), 32'd0);
            check_value("reset irq_pending", 32'(irq_pending), 32'd0);
        end
        rst = 1'b0;
        for (int i = 0; i < rows_q.size(); i++) begin
            apply_stim(rows_q[i].stim);
            @(posedge clk);
            @(negedge clk);
            compare_row(i, rows_q[i].want);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        int limit_ns;
        wait (built);
        // one 4 ns cycle per row plus reset and slack
        limit_ns = (RST_CYCLES + rows_q.size() + 25) * 4;
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
